// ==== design/mem/system_rom.mem ====
// system rom image, one 16-bit hex word per line
// line n holds the word at rom index n (address bits 4..0)
83E0
0024
0900
0A00
C0A1
0300
0460
0A36
D820
8C02
0201
4000
06A0
0B3C
1300
10FE
2FE0
C80B
0380
045B
B1C2
7E4D
3A95
E617
5C08
91F3
0D6E
F4A1
28B7
6C59
AE30
1F0D

// ==== ti_memory_top.f ====
+incdir+testbench
design/ti_mem_map_pkg.sv
design/ti_bus_pkg.sv
design/mem_map_decode.sv
design/rom_store.sv
design/ram_store.sv
design/read_mux.sv
design/ti_memory_top.sv
testbench/ti_memory_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the ti_memory testbench with verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module ti_memory_tb -f ti_memory_top.f \
  --Mdir obj_dir -o ti_memory_sim

./obj_dir/ti_memory_sim | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

// ==== testbench/ti_memory_model.svh ====
/*
 * ti_memory_model
 * reference memory map: region decode, expansion fold, byte lanes,
 * expected word for every read
 */
`ifndef TI_MEMORY_MODEL_SVH
`define TI_MEMORY_MODEL_SVH

word_t model_rom [32];   // same image as the dut rom
byte_t model_mem [int];  // sparse, key = 2*word + lane

function automatic region_e decode_region(input logic [ADDR_W-1:0] adr);
  logic [10:0] pg;
  logic [2:0]  bk;
  pg = adr[22:12];
  bk = adr[14:12];
  if (pg == 11'h000)
    return REG_ROM;
  if (adr[22:9] == 14'h0040)
    return REG_PAD;
  if (pg inside {11'h002, 11'h00A, [11'h00C:11'h00F]})
    return REG_RAM_EXP;  // beats the grom window
  if (adr[22:15] == 8'h01 && bk >= 3'd3 && bk <= 3'd6)
    return REG_GROM_EXT;
  return REG_NONE;
endfunction

// word slot inside the writable stores, -1 for rom and unmapped
function automatic int store_key(input logic [ADDR_W-1:0] adr);
  case (decode_region(adr))
    REG_PAD:      return 32'h1_0000 + int'(adr[8:0]);
    REG_GROM_EXT: return 32'h2_0000 + int'(adr[13:0]);
    REG_RAM_EXP:
      if (adr[14:12] == 3'd2)
        return 32'h3_0000 + int'(adr[11:0]);  // 2000..3FFF folds to 0
      else
        return 32'h3_0000 + int'(adr[13:0]);
    default:      return -1;
  endcase
endfunction

function automatic void apply_write(input logic [ADDR_W-1:0] adr, input word_t data,
                                    input logic lb_n, input logic ub_n);
  int key;
  key = store_key(adr);
  if (key < 0)
    return;                            // rom and holes ignore writes
  if (!lb_n)
    model_mem[2*key] = data[7:0];      // lb lane
  if (!ub_n)
    model_mem[2*key+1] = data[15:8];   // ub lane
endfunction

function automatic word_t expected_read(input logic [ADDR_W-1:0] adr);
  int    key;
  byte_t lo;
  byte_t hi;
  if (decode_region(adr) == REG_ROM)
    return model_rom[adr[4:0]];        // mirrored every 32 words
  key = store_key(adr);
  if (key < 0)
    return 16'h0000;
  lo = model_mem.exists(2*key) ? model_mem[2*key] : 8'h00;
  hi = model_mem.exists(2*key+1) ? model_mem[2*key+1] : 8'h00;
  return {hi, lo};
endfunction

`endif

// ==== testbench/ti_memory_tb.sv ====
`timescale 1ns/1ns
/*
 * ti_memory_tb
 * directed and random traffic into the memory system, every read
 * response scored against the reference model and its due cycle
 */
module ti_memory_tb
  import ti_bus_pkg::*, ti_mem_map_pkg::*;
();

  logic              clk;
  logic              i_arst_n;
  logic              i_req;
  logic              i_we_n;
  logic              i_lb_n;
  logic              i_ub_n;
  logic [ADDR_W-1:0] i_adr;
  word_t             i_wdata;
  logic              o_rvalid;
  word_t             o_rdata;

  integer            seed = 32'h1cd2c366;
  int                cyc = 0;           // bumped on every negedge
  int                data_errors = 0;
  int                proto_errors = 0;
  word_t             exp_q [$];         // expected read words, in order
  int                due_q [$];         // negedge count each read is due
  logic [ADDR_W-1:0] pool [16];         // random traffic targets
  logic [10:0]       ram_pages [6] = '{11'h002, 11'h00A, 11'h00C, 11'h00D, 11'h00E, 11'h00F};

  `include "ti_memory_model.svh"

  ti_memory_top ti_memory_top_inst (
    .clk     (clk),
    .i_arst_n(i_arst_n),
    .i_req   (i_req),
    .i_we_n  (i_we_n),
    .i_lb_n  (i_lb_n),
    .i_ub_n  (i_ub_n),
    .i_adr   (i_adr),
    .i_wdata (i_wdata),
    .o_rvalid(o_rvalid),
    .o_rdata (o_rdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  task automatic check_val(input string name, input word_t got, input word_t want);
    if (got !== want)
    begin
      data_errors++;
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, want);
    end
  endtask

  // one request; the model sees it in issue order
  task automatic access(input logic we_n, input logic lb_n, input logic ub_n,
                        input logic [ADDR_W-1:0] adr, input word_t wdata);
    @(posedge clk);
    i_req   <= 1'b1;
    i_we_n  <= we_n;
    i_lb_n  <= lb_n;
    i_ub_n  <= ub_n;
    i_adr   <= adr;
    i_wdata <= wdata;
    if (we_n)
    begin
      exp_q.push_back(expected_read(adr));
      due_q.push_back(cyc + READ_LATENCY + 1);  // +1, driven a cycle before capture
    end
    else
      apply_write(adr, wdata, lb_n, ub_n);
  endtask

  task automatic read_word(input logic [ADDR_W-1:0] adr);
    access(1'b1, 1'b0, 1'b0, adr, 16'h0000);
  endtask

  task automatic write_word(input logic [ADDR_W-1:0] adr, input word_t data,
                            input logic lb_n, input logic ub_n);
    access(1'b0, lb_n, ub_n, adr, data);
  endtask

  task automatic bus_idle();
    @(posedge clk);
    i_req  <= 1'b0;
    i_we_n <= 1'b1;
  endtask

  // full word, then each lane alone
  task automatic lane_test(input logic [ADDR_W-1:0] base);
    write_word(base, 16'hC35A ^ base[15:0], 1'b0, 1'b0);
    write_word(base, 16'h00EE, 1'b0, 1'b1);  // lb only
    read_word(base);
    write_word(base, 16'h7100, 1'b1, 1'b0);  // ub only
    read_word(base);
    bus_idle();
  endtask

  task automatic drain_reads(output bit drained);
    int t;
    t = 0;
    while (exp_q.size() > 0 && t < 20)
    begin
      @(posedge clk);
      t++;
    end
    drained = (exp_q.size() == 0);
    for (t = 0; t < 4; t++)
      @(posedge clk);                        // room for a stray pulse
  endtask

  // ==================================================
  // response scoreboard, sampled mid-cycle
  // ==================================================
  initial
  begin
    forever
    begin
      @(negedge clk);
      cyc = cyc + 1;
      if (!i_arst_n)
      begin
        check_val("o_rvalid", {15'd0, o_rvalid}, 16'h0000);
        check_val("o_rdata", o_rdata, 16'h0000);
      end
      else if (o_rvalid)
      begin
        if (exp_q.size() == 0)
        begin
          proto_errors++;
          $display("read response at cycle %0d with no read outstanding", cyc);
        end
        else
        begin
          if (cyc != due_q[0])
          begin
            proto_errors++;
            $display("read response at cycle %0d, it was due at cycle %0d", cyc, due_q[0]);
          end
          check_val("o_rdata", o_rdata, exp_q.pop_front());
          void'(due_q.pop_front());
        end
      end
      else if (due_q.size() > 0 && cyc > due_q[0])
      begin
        proto_errors++;
        $display("no read response arrived for the read due at cycle %0d", due_q[0]);
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
      end
    end
  end

  // ==================================================
  // stimulus
  // ==================================================
  initial
  begin
    int          k;
    logic [31:0] rnd;
    bit          drained;
    i_arst_n = 1'b0;
    i_req    = 1'b0;
    i_we_n   = 1'b1;
    i_lb_n   = 1'b1;
    i_ub_n   = 1'b1;
    i_adr    = '0;
    i_wdata  = '0;
    $readmemh(ROM_FILE, model_rom);
    repeat (5) @(posedge clk);
    i_arst_n <= 1'b1;
    @(posedge clk);

    for (k = 0; k < 32; k++)
      read_word(23'(k));
    read_word(23'h000FE7);                   // mirrors
    read_word(23'h000A5F);
    write_word(23'h000003, 16'hDEAD, 1'b0, 1'b0);  // rom ignores it
    read_word(23'h000003);
    read_word(23'h000FE3);
    bus_idle();

    lane_test(23'h0080A7);  // scratchpad
    lane_test(23'h00B3C5);  // grom ext, page 3
    lane_test(23'h00D456);  // ram expansion

    // expansion fold and distinct banks
    write_word(23'h002123, 16'h2002, 1'b0, 1'b0);
    write_word(23'h00D123, 16'hD00D, 1'b0, 1'b0);
    write_word(23'h00E123, 16'hE00E, 1'b0, 1'b0);
    write_word(23'h00F123, 16'hF00F, 1'b0, 1'b0);
    read_word(23'h002123);
    read_word(23'h00A123);
    read_word(23'h00C123);
    read_word(23'h00D123);
    read_word(23'h00E123);
    read_word(23'h00F123);
    bus_idle();

    // holes and system grom pages
    write_word(23'h009040, 16'hBEEF, 1'b0, 1'b0);
    read_word(23'h009040);
    read_word(23'h008200);
    read_word(23'h001000);
    read_word(23'h010000);
    read_word(23'h7FFFFF);
    bus_idle();

    // random pool, writable slots filled first
    for (k = 0; k < 16; k++)
    begin
      rnd = $random(seed);
      case (rnd[2:0])
        3'd0, 3'd1: pool[k] = {14'h0040, rnd[16:8]};
        3'd2:       pool[k] = {11'h00B, rnd[19:8]};
        3'd3, 3'd4: pool[k] = {ram_pages[rnd[5:3] % 3'd6], rnd[19:8]};
        3'd5:       pool[k] = {11'h000, rnd[19:8]};
        default:    pool[k] = {3'b001, rnd[27:8]};  // far above the map
      endcase
      if (decode_region(pool[k]) inside {REG_PAD, REG_GROM_EXT, REG_RAM_EXP})
        write_word(pool[k], rnd[31:16], 1'b0, 1'b0);
    end
    for (k = 0; k < 200; k++)
    begin
      rnd = $random(seed);
      if (rnd[5:4] != 2'b00)
        read_word(pool[rnd[3:0]]);
      else
        write_word(pool[rnd[3:0]], rnd[31:16], rnd[6], rnd[7]);
    end
    bus_idle();

    drain_reads(drained);
    if (!drained)
    begin
      proto_errors++;
      $display("timeout: %0d read responses still outstanding", exp_q.size());
    end
    $display("error counts: %0d data mismatches, %0d protocol errors",
             data_errors, proto_errors);
    if (data_errors + proto_errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== design/ti_memory_top.sv ====
`timescale 1ns/1ns
/*
 * ti_memory_top
 * CPU-side memory system: decode, ROM and RAM stores side by side,
 * read combiner; reads return after a fixed 3-cycle pipeline
 */
module ti_memory_top
  import ti_bus_pkg::*, ti_mem_map_pkg::*;
(
  input  logic              clk,
  input  logic              i_arst_n,
  input  logic              i_req,     // single-cycle strobe
  input  logic              i_we_n,
  input  logic              i_lb_n,
  input  logic              i_ub_n,
  input  logic [ADDR_W-1:0] i_adr,
  input  word_t             i_wdata,
  output logic              o_rvalid,
  output word_t             o_rdata
);

  // ==================================================
  // stage 1 -> stage 2
  // ==================================================
  logic              d_valid;
  logic              d_rd;
  region_e           d_region;
  logic [ROM_AW-1:0] d_rom_idx;
  logic [PAD_AW-1:0] d_pad_idx;
  logic [EXP_AW-1:0] d_exp_idx;
  logic [EXP_AW-1:0] d_ram_idx;
  word_t             d_wdata;
  logic              d_we_lo;
  logic              d_we_hi;

  // stage 2 -> stage 3
  word_t   rom_word;
  word_t   ram_word;
  region_e s_region;
  logic    s_rd_valid;

  mem_map_decode mem_map_decode_inst (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_req    (i_req),
    .i_we_n   (i_we_n),
    .i_lb_n   (i_lb_n),
    .i_ub_n   (i_ub_n),
    .i_adr    (i_adr),
    .i_wdata  (i_wdata),
    .o_valid  (d_valid),
    .o_rd     (d_rd),
    .o_region (d_region),
    .o_rom_idx(d_rom_idx),
    .o_pad_idx(d_pad_idx),
    .o_exp_idx(d_exp_idx),
    .o_ram_idx(d_ram_idx),
    .o_wdata  (d_wdata),
    .o_we_lo  (d_we_lo),
    .o_we_hi  (d_we_hi)
  );

  rom_store rom_store_inst (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_valid   (d_valid),
    .i_rd      (d_rd),
    .i_region  (d_region),
    .i_rom_idx (d_rom_idx),
    .o_word    (rom_word),
    .o_region  (s_region),    // side-band rides with the rom
    .o_rd_valid(s_rd_valid)
  );

  ram_store ram_store_inst (
    .clk      (clk),
    .i_valid  (d_valid),
    .i_region (d_region),
    .i_pad_idx(d_pad_idx),
    .i_exp_idx(d_exp_idx),
    .i_ram_idx(d_ram_idx),
    .i_wdata  (d_wdata),
    .i_we_lo  (d_we_lo),
    .i_we_hi  (d_we_hi),
    .o_word   (ram_word)
  );

  read_mux read_mux_inst (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_rd_valid(s_rd_valid),
    .i_region  (s_region),
    .i_rom_word(rom_word),
    .i_ram_word(ram_word),
    .o_rvalid  (o_rvalid),
    .o_rdata   (o_rdata)
  );

endmodule

// ==== design/read_mux.sv ====
`timescale 1ns/1ns
/*
 * read_mux
 * stage 3: picks the ROM or RAM word by region and registers
 * the read response, zero for unmapped reads
 */
module read_mux
  import ti_bus_pkg::*;
(
  input  logic    clk,
  input  logic    i_arst_n,
  input  logic    i_rd_valid,
  input  region_e i_region,
  input  word_t   i_rom_word,
  input  word_t   i_ram_word,
  output logic    o_rvalid,
  output word_t   o_rdata
);

  word_t sel_word;

  always_comb
  begin
    case (i_region)
      REG_ROM:                            sel_word = i_rom_word;
      REG_PAD, REG_GROM_EXT, REG_RAM_EXP: sel_word = i_ram_word;
      default:                            sel_word = '0;  // unmapped
    endcase
  end

  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      o_rvalid <= 1'b0;
      o_rdata  <= '0;
    end
    else
    begin
      o_rvalid <= i_rd_valid;                       // one-cycle pulse
      o_rdata  <= i_rd_valid ? sel_word : word_t'(0); // bus idles at 0
    end
  end

endmodule

// ==== design/ram_store.sv ====
`timescale 1ns/1ns
/*
 * ram_store
 * stage 2: byte-lane RAM for scratchpad, GROM extension and
 * the 32K expansion; writes enabled lanes, registers the read word
 */
module ram_store
  import ti_bus_pkg::*, ti_mem_map_pkg::*;
(
  input  logic              clk,
  input  logic              i_valid,
  input  region_e           i_region,
  input  logic [PAD_AW-1:0] i_pad_idx,
  input  logic [EXP_AW-1:0] i_exp_idx,
  input  logic [EXP_AW-1:0] i_ram_idx,
  input  word_t             i_wdata,
  input  logic              i_we_lo,
  input  logic              i_we_hi,
  output word_t             o_word
);

  // ==================================================
  // lane arrays
  // ==================================================
  byte_t pad_lo  [2**PAD_AW];
  byte_t pad_hi  [2**PAD_AW];
  byte_t grom_lo [2**EXP_AW];
  byte_t grom_hi [2**EXP_AW];
  byte_t ram_lo  [2**EXP_AW];
  byte_t ram_hi  [2**EXP_AW];

  word_t   pad_q, grom_q, ram_q;
  region_e sel_q;               // which store to forward
  logic    pad_sel, grom_sel, ram_sel;

  assign pad_sel  = (i_region == REG_PAD);
  assign grom_sel = (i_region == REG_GROM_EXT);
  assign ram_sel  = (i_region == REG_RAM_EXP);

  always_ff @(posedge clk)
  begin
    if (pad_sel && i_we_lo) pad_lo[i_pad_idx] <= i_wdata[7:0];
    if (pad_sel && i_we_hi) pad_hi[i_pad_idx] <= i_wdata[15:8];
    if (i_valid) pad_q <= {pad_hi[i_pad_idx], pad_lo[i_pad_idx]};
  end

  always_ff @(posedge clk)
  begin
    if (grom_sel && i_we_lo) grom_lo[i_exp_idx] <= i_wdata[7:0];
    if (grom_sel && i_we_hi) grom_hi[i_exp_idx] <= i_wdata[15:8];
    if (i_valid) grom_q <= {grom_hi[i_exp_idx], grom_lo[i_exp_idx]};
  end

  // expansion uses the folded offset
  always_ff @(posedge clk)
  begin
    if (ram_sel && i_we_lo) ram_lo[i_ram_idx] <= i_wdata[7:0];
    if (ram_sel && i_we_hi) ram_hi[i_ram_idx] <= i_wdata[15:8];
    if (i_valid) ram_q <= {ram_hi[i_ram_idx], ram_lo[i_ram_idx]};
  end

  always_ff @(posedge clk)
  begin
    sel_q <= i_region;
  end

  always_comb
  begin
    case (sel_q)
      REG_PAD:      o_word = pad_q;
      REG_GROM_EXT: o_word = grom_q;
      REG_RAM_EXP:  o_word = ram_q;
      default:      o_word = '0;
    endcase
  end

  // lane enables from the decoder only come with a live request
  a_we_valid: assert property (@(posedge clk) (i_we_lo || i_we_hi) |-> i_valid);

endmodule

// ==== design/rom_store.sv ====
`timescale 1ns/1ns
/*
 * rom_store
 * stage 2: preloaded system ROM, registered read, carries the
 * region and read flag one stage forward
 */
module rom_store
  import ti_bus_pkg::*, ti_mem_map_pkg::*;
(
  input  logic              clk,
  input  logic              i_arst_n,
  input  logic              i_valid,
  input  logic              i_rd,
  input  region_e           i_region,
  input  logic [ROM_AW-1:0] i_rom_idx,
  output word_t             o_word,
  output region_e           o_region,
  output logic              o_rd_valid
);

  word_t rom [ROM_WORDS];

  initial
  begin
    $readmemh(ROM_FILE, rom);
  end

  always_ff @(posedge clk)
  begin
    o_word <= rom[i_rom_idx];  // sync read
  end

  // side-band for the combiner
  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      o_region   <= REG_NONE;
      o_rd_valid <= 1'b0;
    end
    else
    begin
      o_region   <= i_region;
      o_rd_valid <= i_valid & i_rd;
    end
  end

  // idle stage from the decoder must never select a store
  a_idle_none: assert property (@(posedge clk) disable iff (!i_arst_n)
    !i_valid |-> (i_region == REG_NONE));

endmodule

// ==== design/mem_map_decode.sv ====
`timescale 1ns/1ns
/*
 * mem_map_decode
 * stage 1: decodes the word address into a region, folds the 32K
 * expansion into one block and qualifies the byte-lane write enables
 */
module mem_map_decode
  import ti_bus_pkg::*, ti_mem_map_pkg::*;
(
  input  logic              clk,
  input  logic              i_arst_n,
  input  logic              i_req,
  input  logic              i_we_n,
  input  logic              i_lb_n,
  input  logic              i_ub_n,
  input  logic [ADDR_W-1:0] i_adr,
  input  word_t             i_wdata,
  output logic              o_valid,
  output logic              o_rd,
  output region_e           o_region,
  output logic [ROM_AW-1:0] o_rom_idx,
  output logic [PAD_AW-1:0] o_pad_idx,
  output logic [EXP_AW-1:0] o_exp_idx,
  output logic [EXP_AW-1:0] o_ram_idx,
  output word_t             o_wdata,
  output logic              o_we_lo,
  output logic              o_we_hi
);

  logic [PAGE_W-1:0] page;
  logic [2:0]        bank;      // bits 14..12
  logic              ram_hit;
  logic              grom_ext;
  logic              wr_ok;     // write into a writable store
  region_e           region_d;

  assign page = i_adr[ADDR_W-1:PAGE_LSB];
  assign bank = i_adr[PAGE_LSB+2:PAGE_LSB];
  assign grom_ext = (bank >= GROM_EXT_FIRST) && (bank <= GROM_EXT_LAST);

  always_comb
  begin
    ram_hit = 1'b0;
    for (int k = 0; k < RAM_EXP_N; k++)
    begin
      if (page == RAM_EXP_PAGES[k])
        ram_hit = 1'b1;
    end
  end

  // ==================================================
  // region priority: rom, pad, ram exp, then grom
  // ==================================================
  always_comb
  begin
    if (!i_req)
      region_d = REG_NONE;                              // idle cycle
    else if (page == ROM_TAG)
      region_d = REG_ROM;
    else if (i_adr[ADDR_W-1:PAD_AW] == PAD_TAG)
      region_d = REG_PAD;
    else if (ram_hit)
      region_d = REG_RAM_EXP;                           // wins over grom window
    else if ((i_adr[ADDR_W-1:GROM_LSB] == GROM_TAG) && grom_ext)
      region_d = REG_GROM_EXT;
    else
      region_d = REG_NONE;                              // system grom etc read 0
  end

  assign wr_ok = i_req && !i_we_n &&
                 (region_d inside {REG_PAD, REG_GROM_EXT, REG_RAM_EXP});

  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      o_valid  <= 1'b0;
      o_rd     <= 1'b0;
      o_region <= REG_NONE;
      o_we_lo  <= 1'b0;
      o_we_hi  <= 1'b0;
    end
    else
    begin
      o_valid  <= i_req;
      o_rd     <= i_req & i_we_n;
      o_region <= region_d;
      o_we_lo  <= wr_ok & ~i_lb_n;  // lb = bits 7..0
      o_we_hi  <= wr_ok & ~i_ub_n;  // ub = bits 15..8
    end
  end

  // indices and write data
  always_ff @(posedge clk)
  begin
    o_rom_idx <= i_adr[ROM_AW-1:0];  // mirrored over the 4K page
    o_pad_idx <= i_adr[PAD_AW-1:0];
    o_exp_idx <= i_adr[EXP_AW-1:0];
    // 2000..3FFF lands at offset 0, others keep bits 13..12
    o_ram_idx <= {(bank == RAM_LOW_BANK) ? 2'b00 : i_adr[PAGE_LSB+1:PAGE_LSB],
                  i_adr[PAGE_LSB-1:0]};
    o_wdata   <= i_wdata;
  end

endmodule

// ==== design/ti_bus_pkg.sv ====
/*
 * ti_bus_pkg
 * data types of the CPU memory bus, region select encoding
 * and the read pipeline depth
 */
package ti_bus_pkg;

  typedef logic [15:0] word_t;  // cpu data word
  typedef logic [7:0]  byte_t;  // one byte lane

  // which store answers an access
  typedef enum logic [2:0] {
    REG_NONE     = 3'd0,  // unmapped, reads zero
    REG_ROM      = 3'd1,
    REG_PAD      = 3'd2,
    REG_GROM_EXT = 3'd3,
    REG_RAM_EXP  = 3'd4
  } region_e;

  // decode + store + combiner
  localparam int READ_LATENCY = 3;

endpackage

// ==== design/ti_mem_map_pkg.sv ====
/*
 * ti_mem_map_pkg
 * CPU-side memory map: address widths, store sizes and the upper-address
 * tags that select the ROM, scratchpad, GROM extension and RAM expansion
 */
package ti_mem_map_pkg;

  // ==================================================
  // widths and sizes
  // ==================================================
  localparam int ADDR_W    = 23;                 // word address from the cpu bus
  localparam int PAGE_LSB  = 12;                 // 4K-word pages
  localparam int PAGE_W    = ADDR_W - PAGE_LSB;  // bits 22..12
  localparam int GROM_LSB  = 15;                 // grom window tag starts here
  localparam int ROM_WORDS = 32;                 // stored rom words, mirrored
  localparam int ROM_AW    = $clog2(ROM_WORDS);
  localparam int PAD_AW    = 9;                  // 512 words = 1K bytes
  localparam int EXP_AW    = 14;                 // 16K words each

  // ==================================================
  // region tags
  // ==================================================
  localparam logic [PAGE_W-1:0]          ROM_TAG  = '0;       // bits 22..12
  localparam logic [ADDR_W-PAD_AW-1:0]   PAD_TAG  = 14'h0040; // bits 22..9
  localparam logic [ADDR_W-GROM_LSB-1:0] GROM_TAG = 8'h01;    // bits 22..15

  // grom pages 3..6 (bits 14..12) hold the cartridge extension
  localparam logic [2:0] GROM_EXT_FIRST = 3'd3;
  localparam logic [2:0] GROM_EXT_LAST  = 3'd6;

  // ram expansion pages, bits 22..12
  localparam int RAM_EXP_N = 6;
  localparam logic [PAGE_W-1:0] RAM_EXP_PAGES [RAM_EXP_N] = '{
    11'h002, 11'h00A, 11'h00C, 11'h00D, 11'h00E, 11'h00F
  };
  localparam logic [2:0] RAM_LOW_BANK = 3'd2;  // folds onto offset 0

  localparam string ROM_FILE = "design/mem/system_rom.mem";

endpackage
